// File: list.f
wb_bus_pkg.sv
soc_map_pkg.sv
wb_slave_ctrl.sv
sys_ram.sv
sys_manager.sv
foc_reg_bank.sv
partition_top.sv
tb_partition_top.sv

// File: tb_partition_top.sv
`timescale 1ns/1ps

module tb_partition_top;

  import wb_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int NB        = 10;    // FOC register bytes
  localparam int RAM_WORDS = 512;
  localparam int ACK_LIMIT = 20;    // Cycles to wait for an ack

  logic                 wb_clk_i = 1'b0;
  logic                 arst_n_i;
  logic                 wbs_cyc_i;
  logic                 wbs_stb_i;
  logic                 wbs_we_i;
  wb_sel_t              wbs_sel_i;
  wb_addr_t             wbs_adr_i;
  wb_data_t             wbs_dat_i;
  logic                 wbs_ack_o;
  wb_data_t             wbs_dat_o;
  logic                 proc_rst_n_o;
  logic [NB-1:0][7:0]   foc_reg_d_i;
  logic [NB-1:0]        foc_reg_load_i;
  logic [NB-1:0][7:0]   foc_reg_q_o;
  logic [NB-1:0]        foc_wr_active_o;
  logic [NB-1:0]        foc_rd_active_o;

  // Shadow model
  wb_data_t             ram_m [RAM_WORDS];
  logic                 ctrl_m = 1'b0;
  wb_data_t             scratch_m = '0;
  logic [NB-1:0][7:0]   foc_m = '0;

  // Expectations for the comparing process
  wb_data_t             exp_dat;
  logic                 chk_dat = 1'b0;
  logic [NB-1:0]        exp_wact;
  logic [NB-1:0]        exp_ract;
  logic                 run_chk = 1'b0;    // Off during reset

  int                   errors = 0;
  int                   checks = 0;
  int                   err_mark = 0;      // Error count at test start
  integer               seed;

  always #5 wb_clk_i = ~wb_clk_i;          // 10 ns period

  partition_top #(
    .RAM_WORDS     (RAM_WORDS),
    .REG_NUM_BYTES (NB)
  ) partition_top_inst (.*);

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic wb_data_t ref_read(input wb_addr_t addr);
    int       off;
    wb_data_t r;
    off = int'(addr[11:2]);
    r   = '0;                                          // Unmapped and holes read zero
    if (addr[31:12] == RAM_BASE[31:12]) begin
      r = ram_m[off % RAM_WORDS];                      // Upper 2 KB aliases
    end else if (addr[31:12] == SYS_BASE[31:12]) begin
      if (off == 0) r = {31'b0, ctrl_m};
      if (off == 1) r = scratch_m;
      if (off == 2) r = SYS_ID_VALUE;
    end else if (addr[31:12] == FOC_BASE[31:12]) begin
      for (int l = 0; l < WB_SEL_W; l++) begin
        if (off * 4 + l < NB) r[8*l +: 8] = foc_m[off * 4 + l];
      end
    end
    return r;
  endfunction

  function automatic void model_write(input wb_addr_t addr, input wb_sel_t sel,
                                      input wb_data_t data);
    int off;
    off = int'(addr[11:2]);
    for (int l = 0; l < WB_SEL_W; l++) begin
      if (sel[l]) begin
        if (addr[31:12] == RAM_BASE[31:12]) ram_m[off % RAM_WORDS][8*l +: 8] = data[8*l +: 8];
        if (addr[31:12] == SYS_BASE[31:12] && off == 1) scratch_m[8*l +: 8] = data[8*l +: 8];
        if (addr[31:12] == SYS_BASE[31:12] && off == 0 && l == 0) ctrl_m = data[0];
        if (addr[31:12] == FOC_BASE[31:12] && off * 4 + l < NB) begin
          foc_m[off * 4 + l] = data[8*l +: 8];
        end
      end
    end
  endfunction

  // Existing, selected FOC bytes of one access
  function automatic logic [NB-1:0] touched_bytes(input wb_addr_t addr, input wb_sel_t sel);
    int            off;
    logic [NB-1:0] t;
    off = int'(addr[11:2]);
    t   = '0;
    if (addr[31:12] == FOC_BASE[31:12]) begin
      for (int l = 0; l < WB_SEL_W; l++) begin
        if (sel[l] && off * 4 + l < NB) t[off * 4 + l] = 1'b1;   // Lane l of word off
      end
    end
    return t;
  endfunction

  //////////////////////////////////////////////////
  // Checks and bus access
  //////////////////////////////////////////////////

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %-10s %s, %0d failed checks", name,
             (errors == err_mark) ? "passed" : "FAILED", errors - err_mark);
    err_mark = errors;
  endtask

  // Sampled before the edge updates anything
  always @(posedge wb_clk_i) begin
    if (run_chk) begin
      if (wbs_cyc_i && wbs_stb_i && !wbs_ack_o) begin       // Acceptance cycle
        check(foc_wr_active_o, exp_wact, "write activity");
        check(foc_rd_active_o, exp_ract, "read activity");
      end else begin
        check(foc_wr_active_o | foc_rd_active_o, '0, "activity outside a request");
      end
      if (!wbs_cyc_i) check(wbs_ack_o, 1'b0, "ack outside a transfer");
      if (wbs_ack_o && chk_dat) check(wbs_dat_o, exp_dat, $sformatf("read %h", wbs_adr_i));
    end
  end

  task automatic bus_xfer(input logic we, input wb_addr_t addr, input wb_sel_t sel,
                          input wb_data_t data, input logic [NB-1:0] load = '0,
                          input logic [NB-1:0][7:0] ld_data = '0);
    int n_cyc;
    @(negedge wb_clk_i);
    chk_dat  = !we;
    exp_dat  = ref_read(addr);
    exp_wact = touched_bytes(addr, sel) & {NB{we}};
    exp_ract = touched_bytes(addr, sel) & {NB{!we}};
    if (we) model_write(addr, sel, data);
    for (int n = 0; n < NB; n++) begin
      if (load[n]) foc_m[n] = ld_data[n];             // Load beats the bus
    end
    wbs_cyc_i      = 1'b1;
    wbs_stb_i      = 1'b1;
    wbs_we_i       = we;
    wbs_sel_i      = sel;
    wbs_adr_i      = addr;
    wbs_dat_i      = data;
    foc_reg_load_i = load;
    foc_reg_d_i    = ld_data;
    n_cyc          = 0;
    do begin
      @(posedge wb_clk_i);
      n_cyc++;
    end while (!wbs_ack_o && n_cyc < ACK_LIMIT);
    if (!wbs_ack_o) begin
      errors++;
      $display("No acknowledge arrived within %0d cycles for address %h", ACK_LIMIT, addr);
    end else begin
      check(n_cyc, 2, "ack one cycle after acceptance");
    end
    @(negedge wb_clk_i);
    wbs_cyc_i      = 1'b0;
    wbs_stb_i      = 1'b0;
    foc_reg_load_i = '0;
    chk_dat        = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    wb_addr_t           ram_addr [12];
    logic [NB-1:0][7:0] ld;
    seed           = 32'ha82e1922;
    arst_n_i       = 1'b0;
    wbs_cyc_i      = 1'b0;
    wbs_stb_i      = 1'b0;
    wbs_we_i       = 1'b0;
    wbs_sel_i      = '0;
    wbs_adr_i      = '0;
    wbs_dat_i      = '0;
    foc_reg_d_i    = '0;
    foc_reg_load_i = '0;
    repeat (2) @(posedge wb_clk_i);                   // Reset for 2 cycles
    @(negedge wb_clk_i);
    arst_n_i = 1'b1;

    check(wbs_ack_o, 0, "ack after reset");
    check(proc_rst_n_o, 0, "processor reset after reset");
    check(foc_reg_q_o, '0, "FOC registers after reset");
    check(foc_wr_active_o | foc_rd_active_o, '0, "activity after reset");
    run_chk = 1'b1;
    end_test("reset");

    // Full word first, then a random byte merge
    for (int i = 0; i < 12; i++) begin
      ram_addr[i] = RAM_BASE + ({$random(seed)} % 1024) * 4;
      bus_xfer(1'b1, ram_addr[i], 4'hF, $random(seed));
      bus_xfer(1'b1, ram_addr[i], $random(seed), $random(seed));
    end
    bus_xfer(1'b1, RAM_BASE + 600 * 4, 4'hF, 32'hA5A5_0258);
    bus_xfer(1'b0, RAM_BASE + 88 * 4, 4'hF, '0);      // Alias of word 600
    for (int i = 0; i < 12; i++) bus_xfer(1'b0, ram_addr[i], 4'hF, '0);
    end_test("ram");

    bus_xfer(1'b1, SYS_BASE, 4'hF, 32'hFFFF_FFFF);
    check(proc_rst_n_o, 1, "processor reset released");
    bus_xfer(1'b0, SYS_BASE, 4'hF, '0);               // Upper bits read zero
    bus_xfer(1'b1, SYS_BASE, 4'hF, 32'h0);
    check(proc_rst_n_o, 0, "processor reset held");
    bus_xfer(1'b1, SYS_BASE + 4, 4'hF, $random(seed));
    bus_xfer(1'b1, SYS_BASE + 4, 4'b0101, $random(seed));
    bus_xfer(1'b0, SYS_BASE + 4, 4'hF, '0);
    bus_xfer(1'b0, SYS_BASE + 8, 4'hF, '0);
    bus_xfer(1'b1, SYS_BASE + 8, 4'hF, $random(seed));   // ID ignores writes
    bus_xfer(1'b0, SYS_BASE + 8, 4'hF, '0);
    bus_xfer(1'b0, SYS_BASE + 12, 4'hF, '0);
    end_test("sys");

    for (int w = 0; w < 3; w++) begin
      bus_xfer(1'b1, FOC_BASE + w * 4, $random(seed), $random(seed));
      bus_xfer(1'b0, FOC_BASE + w * 4, 4'hF, '0);
      bus_xfer(1'b0, FOC_BASE + w * 4, $random(seed), '0);  // Partial read activity
    end
    check(foc_reg_q_o, foc_m, "FOC registers after bus writes");
    end_test("foc_bus");

    // Bytes 0 and 1 loaded, 2 and 3 from the bus
    ld = {$random(seed), $random(seed), $random(seed)};
    bus_xfer(1'b1, FOC_BASE, 4'hF, $random(seed), 10'b00_0000_0011, ld);
    check(foc_reg_q_o, foc_m, "FOC registers after load");
    bus_xfer(1'b0, FOC_BASE, 4'hF, '0);
    end_test("foc_load");

    // Known RAM word 0 so an aliased write would show
    bus_xfer(1'b1, RAM_BASE, 4'hF, $random(seed));
    bus_xfer(1'b1, 32'h3000_3000, 4'hF, $random(seed));
    bus_xfer(1'b0, 32'h3000_3000, 4'hF, '0);
    bus_xfer(1'b0, RAM_BASE, 4'hF, '0);
    bus_xfer(1'b0, SYS_BASE + 4, 4'hF, '0);
    check(foc_reg_q_o, foc_m, "FOC registers after unmapped write");
    check(proc_rst_n_o, ctrl_m, "processor reset after unmapped write");
    end_test("unmapped");

    $display("Summary: %0d checks, %0d failed", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: partition_top.sv
`timescale 1ns/1ps

module partition_top #(
  parameter int RAM_WORDS     = 512,   // RAM depth in words
  parameter int REG_NUM_BYTES = 10     // FOC register bytes
) (
  input  logic                          wb_clk_i,
  input  logic                          arst_n_i,

  // Wishbone classic slave
  input  logic                          wbs_cyc_i,
  input  logic                          wbs_stb_i,
  input  logic                          wbs_we_i,
  input  wb_bus_pkg::wb_sel_t           wbs_sel_i,
  input  wb_bus_pkg::wb_addr_t          wbs_adr_i,
  input  wb_bus_pkg::wb_data_t          wbs_dat_i,
  output logic                          wbs_ack_o,
  output wb_bus_pkg::wb_data_t          wbs_dat_o,

  // Processor reset release
  output logic                          proc_rst_n_o,

  // FOC controller side of the register bank
  input  logic [REG_NUM_BYTES-1:0][7:0] foc_reg_d_i,
  input  logic [REG_NUM_BYTES-1:0]      foc_reg_load_i,
  output logic [REG_NUM_BYTES-1:0][7:0] foc_reg_q_o,
  output logic [REG_NUM_BYTES-1:0]      foc_wr_active_o,
  output logic [REG_NUM_BYTES-1:0]      foc_rd_active_o
);

  import wb_bus_pkg::*;

  // Request fields shared by all slaves
  logic       req_we;
  wb_sel_t    req_sel;
  wb_offset_t req_offset;
  wb_data_t   req_wdata;

  logic       ram_req;
  logic       sys_req;
  logic       foc_req;
  wb_data_t   ram_rdata;
  wb_data_t   sys_rdata;
  wb_data_t   foc_rdata;

  //////////////////////////////////////////////////
  // Bus front end
  //////////////////////////////////////////////////

  wb_slave_ctrl wb_slave_ctrl_inst (
    .wb_clk_i    (wb_clk_i  ),
    .arst_n_i    (arst_n_i  ),
    .wbs_cyc_i   (wbs_cyc_i ),
    .wbs_stb_i   (wbs_stb_i ),
    .wbs_we_i    (wbs_we_i  ),
    .wbs_sel_i   (wbs_sel_i ),
    .wbs_adr_i   (wbs_adr_i ),
    .wbs_dat_i   (wbs_dat_i ),
    .wbs_ack_o   (wbs_ack_o ),
    .wbs_dat_o   (wbs_dat_o ),
    .ram_rdata_i (ram_rdata ),
    .sys_rdata_i (sys_rdata ),
    .foc_rdata_i (foc_rdata ),
    .ram_req_o   (ram_req   ),
    .sys_req_o   (sys_req   ),
    .foc_req_o   (foc_req   ),
    .we_o        (req_we    ),
    .sel_o       (req_sel   ),
    .offset_o    (req_offset),
    .wdata_o     (req_wdata )
  );

  //////////////////////////////////////////////////
  // Slaves
  //////////////////////////////////////////////////

  sys_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) sys_ram_inst (
    .wb_clk_i (wb_clk_i  ),
    .req_i    (ram_req   ),
    .we_i     (req_we    ),
    .sel_i    (req_sel   ),
    .offset_i (req_offset),
    .wdata_i  (req_wdata ),
    .rdata_o  (ram_rdata )
  );

  sys_manager sys_manager_inst (
    .wb_clk_i     (wb_clk_i    ),
    .arst_n_i     (arst_n_i    ),
    .req_i        (sys_req     ),
    .we_i         (req_we      ),
    .sel_i        (req_sel     ),
    .offset_i     (req_offset  ),
    .wdata_i      (req_wdata   ),
    .rdata_o      (sys_rdata   ),
    .proc_rst_n_o (proc_rst_n_o)
  );

  foc_reg_bank #(
    .REG_NUM_BYTES (REG_NUM_BYTES)
  ) foc_reg_bank_inst (
    .wb_clk_i    (wb_clk_i       ),
    .arst_n_i    (arst_n_i       ),
    .req_i       (foc_req        ),
    .we_i        (req_we         ),
    .sel_i       (req_sel        ),
    .offset_i    (req_offset     ),
    .wdata_i     (req_wdata      ),
    .rdata_o     (foc_rdata      ),
    .reg_d_i     (foc_reg_d_i    ),
    .reg_load_i  (foc_reg_load_i ),
    .reg_q_o     (foc_reg_q_o    ),
    .wr_active_o (foc_wr_active_o),
    .rd_active_o (foc_rd_active_o)
  );

endmodule

// File: foc_reg_bank.sv
`timescale 1ns/1ps

module foc_reg_bank #(
  parameter int REG_NUM_BYTES = 10
) (
  input  logic                          wb_clk_i,
  input  logic                          arst_n_i,

  // Bus request
  input  logic                          req_i,
  input  logic                          we_i,
  input  wb_bus_pkg::wb_sel_t           sel_i,
  input  wb_bus_pkg::wb_offset_t        offset_i,
  input  wb_bus_pkg::wb_data_t          wdata_i,
  output wb_bus_pkg::wb_data_t          rdata_o,

  // Controller side
  input  logic [REG_NUM_BYTES-1:0][7:0] reg_d_i,      // Load values
  input  logic [REG_NUM_BYTES-1:0]      reg_load_i,   // Per-byte load, wins over bus
  output logic [REG_NUM_BYTES-1:0][7:0] reg_q_o,
  output logic [REG_NUM_BYTES-1:0]      wr_active_o,  // Bytes written this cycle
  output logic [REG_NUM_BYTES-1:0]      rd_active_o   // Bytes read this cycle
);

  import wb_bus_pkg::*;

  logic [REG_NUM_BYTES-1:0]      byte_hit;   // Existing, selected, addressed
  logic [REG_NUM_BYTES-1:0][7:0] reg_nxt;
  wb_data_t                      rd_word;

  //////////////////////////////////////////////////
  // Byte address decode
  //////////////////////////////////////////////////

  // Byte n lives in word n/4, lane n%4
  always_comb begin
    for (int n = 0; n < REG_NUM_BYTES; n++) begin
      byte_hit[n] = req_i && (int'(offset_i) == n / 4) && sel_i[n % WB_SEL_W];
    end
  end

  assign wr_active_o = byte_hit & {REG_NUM_BYTES{we_i}};
  assign rd_active_o = byte_hit & {REG_NUM_BYTES{!we_i}};

  //////////////////////////////////////////////////
  // Register update
  //////////////////////////////////////////////////

  always_comb begin
    reg_nxt = reg_q_o;
    for (int n = 0; n < REG_NUM_BYTES; n++) begin
      if (reg_load_i[n]) begin
        reg_nxt[n] = reg_d_i[n];                       // External load first
      end else if (wr_active_o[n]) begin
        reg_nxt[n] = wdata_i[8*(n % WB_SEL_W) +: 8];
      end
    end
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_q_o <= '0;
    end else begin
      reg_q_o <= reg_nxt;
    end
  end

  // Read word from updated bytes
  always_comb begin
    int idx;
    rd_word = '0;
    for (int l = 0; l < WB_SEL_W; l++) begin
      idx = int'(offset_i) * WB_SEL_W + l;
      if (idx < REG_NUM_BYTES) begin
        rd_word[8*l +: 8] = reg_nxt[idx];
      end                                             // Missing bytes stay zero
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req_i) begin
      rdata_o <= rd_word;
    end
  end

endmodule

// File: sys_manager.sv
`timescale 1ns/1ps

module sys_manager (
  input  logic                   wb_clk_i,
  input  logic                   arst_n_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  wb_bus_pkg::wb_sel_t    sel_i,
  input  wb_bus_pkg::wb_offset_t offset_i,
  input  wb_bus_pkg::wb_data_t   wdata_i,
  output wb_bus_pkg::wb_data_t   rdata_o,
  output logic                   proc_rst_n_o  // Processor reset, low holds the core
);

  import wb_bus_pkg::*;
  import soc_map_pkg::*;

  logic     ctrl_q;       // Reset release bit
  logic     ctrl_d;
  wb_data_t scratch_q;
  wb_data_t scratch_d;
  wb_data_t rd_word;
  sys_reg_e reg_sel;
  logic     reg_hit;      // Offset inside the register file

  assign reg_hit = (offset_i[OFFSET_W-1:2] == '0);
  assign reg_sel = sys_reg_e'(offset_i[1:0]);

  //////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////

  always_comb begin
    ctrl_d    = ctrl_q;
    scratch_d = scratch_q;
    if (req_i && we_i && reg_hit) begin
      case (reg_sel)
        SYS_CTRL: begin
          if (sel_i[0]) ctrl_d = wdata_i[0];   // Only bit 0 is stored
        end
        SYS_SCRATCH: begin
          for (int b = 0; b < WB_SEL_W; b++) begin
            if (sel_i[b]) scratch_d[8*b +: 8] = wdata_i[8*b +: 8];
          end
        end
        default: ;                             // ID and holes ignore writes
      endcase
    end
  end

  // Read word after the write
  always_comb begin
    rd_word = '0;
    if (reg_hit) begin
      case (reg_sel)
        SYS_CTRL:    rd_word = {{(WB_DATA_W-1){1'b0}}, ctrl_d};
        SYS_SCRATCH: rd_word = scratch_d;
        SYS_ID:      rd_word = SYS_ID_VALUE;
        default:     rd_word = '0;             // Offset 3 reads zero
      endcase
    end
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q    <= 1'b0;      // Core held in reset
      scratch_q <= '0;
      rdata_o   <= '0;
    end else if (req_i) begin
      ctrl_q    <= ctrl_d;
      scratch_q <= scratch_d;
      rdata_o   <= rd_word;
    end
  end

  assign proc_rst_n_o = ctrl_q;

endmodule

// File: sys_ram.sv
`timescale 1ns/1ps

module sys_ram #(
  parameter int RAM_WORDS = 512              // 2 KB of 32-bit words
) (
  input  logic                   wb_clk_i,
  input  logic                   req_i,      // One-cycle request
  input  logic                   we_i,
  input  wb_bus_pkg::wb_sel_t    sel_i,
  input  wb_bus_pkg::wb_offset_t offset_i,
  input  wb_bus_pkg::wb_data_t   wdata_i,
  output wb_bus_pkg::wb_data_t   rdata_o     // Valid the cycle after req_i
);

  import wb_bus_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);

  wb_data_t         mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;
  wb_data_t         word_nxt;    // Addressed word after byte merge

  // Window larger than the array, upper part aliases
  assign idx = IDX_W'(int'(offset_i) % RAM_WORDS);

  // Byte-lane merge
  always_comb begin
    word_nxt = mem[idx];
    for (int b = 0; b < WB_SEL_W; b++) begin
      if (we_i && sel_i[b]) begin
        word_nxt[8*b +: 8] = wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[idx] <= word_nxt;
      end
      rdata_o <= word_nxt;       // Read returns the merged word
    end
  end

endmodule

// File: wb_slave_ctrl.sv
`timescale 1ns/1ps

module wb_slave_ctrl (
  input  logic                   wb_clk_i,     // Bus clock
  input  logic                   arst_n_i,     // Async reset, active low

  // Wishbone classic slave
  input  logic                   wbs_cyc_i,
  input  logic                   wbs_stb_i,
  input  logic                   wbs_we_i,
  input  wb_bus_pkg::wb_sel_t    wbs_sel_i,
  input  wb_bus_pkg::wb_addr_t   wbs_adr_i,
  input  wb_bus_pkg::wb_data_t   wbs_dat_i,
  output logic                   wbs_ack_o,
  output wb_bus_pkg::wb_data_t   wbs_dat_o,

  // Read words from the slaves, valid in the ack cycle
  input  wb_bus_pkg::wb_data_t   ram_rdata_i,
  input  wb_bus_pkg::wb_data_t   sys_rdata_i,
  input  wb_bus_pkg::wb_data_t   foc_rdata_i,

  // One-cycle request strobes
  output logic                   ram_req_o,
  output logic                   sys_req_o,
  output logic                   foc_req_o,

  // Shared request fields
  output logic                   we_o,
  output wb_bus_pkg::wb_sel_t    sel_o,
  output wb_bus_pkg::wb_offset_t offset_o,
  output wb_bus_pkg::wb_data_t   wdata_o
);

  import wb_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int WIN_LSB = $clog2(WINDOW_BYTES);   // First address bit above a window

  wb_state_e state_q;
  wb_state_e state_d;
  region_e   region_d;     // Decode of the current address
  region_e   region_q;     // Region of the accepted transfer
  logic      accept;

  //////////////////////////////////////////////////
  // Acceptance and decode
  //////////////////////////////////////////////////

  assign accept = wbs_cyc_i && wbs_stb_i && (state_q == ST_IDLE);

  always_comb begin
    // Compare only the bits above the window
    if (wbs_adr_i[WB_ADDR_W-1:WIN_LSB] == RAM_BASE[WB_ADDR_W-1:WIN_LSB]) begin
      region_d = REGION_RAM;
    end else if (wbs_adr_i[WB_ADDR_W-1:WIN_LSB] == SYS_BASE[WB_ADDR_W-1:WIN_LSB]) begin
      region_d = REGION_SYS;
    end else if (wbs_adr_i[WB_ADDR_W-1:WIN_LSB] == FOC_BASE[WB_ADDR_W-1:WIN_LSB]) begin
      region_d = REGION_FOC;
    end else begin
      region_d = REGION_NONE;    // Unmapped, no strobe
    end
  end

  // Strobes only in the acceptance cycle
  assign ram_req_o = accept && (region_d == REGION_RAM);
  assign sys_req_o = accept && (region_d == REGION_SYS);
  assign foc_req_o = accept && (region_d == REGION_FOC);

  assign we_o     = wbs_we_i;
  assign sel_o    = wbs_sel_i;
  assign offset_o = wbs_adr_i[2 +: OFFSET_W];   // Word offset, byte bits dropped
  assign wdata_o  = wbs_dat_i;

  //////////////////////////////////////////////////
  // FSM and ack
  //////////////////////////////////////////////////

  always_comb begin
    case (state_q)
      ST_IDLE: state_d = accept ? ST_ACK : ST_IDLE;
      ST_ACK:  state_d = ST_IDLE;               // Back to idle after one ack
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= ST_IDLE;
      region_q <= REGION_NONE;
    end else begin
      state_q <= state_d;
      if (accept) begin
        region_q <= region_d;   // Held for the read mux
      end
    end
  end

  assign wbs_ack_o = (state_q == ST_ACK);

  // Read data mux, zero outside the ack cycle
  always_comb begin
    wbs_dat_o = '0;
    if (wbs_ack_o) begin
      case (region_q)
        REGION_RAM: wbs_dat_o = ram_rdata_i;
        REGION_SYS: wbs_dat_o = sys_rdata_i;
        REGION_FOC: wbs_dat_o = foc_rdata_i;
        default:    wbs_dat_o = '0;   // Unmapped reads zero
      endcase
    end
  end

endmodule

// File: soc_map_pkg.sv
package soc_map_pkg;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  localparam logic [31:0] RAM_BASE = 32'h3000_0000;   // Word RAM
  localparam logic [31:0] SYS_BASE = 32'h3000_1000;   // System manager
  localparam logic [31:0] FOC_BASE = 32'h3000_2000;   // FOC byte registers

  // All windows share one size
  localparam int WINDOW_BYTES = 4096;

  // Decode result of the front end
  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_SYS,
    REGION_FOC,
    REGION_NONE               // Outside all windows
  } region_e;

  //////////////////////////////////////////////////
  // System manager registers
  //////////////////////////////////////////////////

  // Word offsets inside the system window
  typedef enum logic [1:0] {
    SYS_CTRL    = 2'd0,       // Bit 0 releases the processor reset
    SYS_SCRATCH = 2'd1,       // Free read/write word
    SYS_ID      = 2'd2        // Read-only identification
  } sys_reg_e;

  // Identification word, ASCII "FOC1"
  localparam logic [31:0] SYS_ID_VALUE = 32'h464F_4331;

endpackage

// File: wb_bus_pkg.sv
package wb_bus_pkg;

  //////////////////////////////////////////////////
  // Wishbone widths
  //////////////////////////////////////////////////

  localparam int WB_ADDR_W = 32;              // Byte address
  localparam int WB_DATA_W = 32;              // One 32-bit word per transfer
  localparam int WB_SEL_W  = WB_DATA_W / 8;   // Byte lanes

  // Word offset inside a 4 KB window
  localparam int OFFSET_W  = 10;

  //////////////////////////////////////////////////
  // Bus data types
  //////////////////////////////////////////////////

  typedef logic [WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [WB_DATA_W-1:0] wb_data_t;
  typedef logic [WB_SEL_W-1:0]  wb_sel_t;   // One bit per byte lane
  typedef logic [OFFSET_W-1:0]  wb_offset_t;

  // Front-end FSM
  typedef enum logic {
    ST_IDLE,                  // Waiting for cyc and stb
    ST_ACK                    // Ack cycle, read data on the bus
  } wb_state_e;

endpackage
